/* build.sh */
#!/bin/sh
# Builds the fixed-order selector testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_NAME=fixedOrderSim
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module fixedOrderTb \
    -Mdir "$BUILD_DIR" -o "$SIM_NAME" \
    -f project.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build returned status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_NAME" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "Simulation returned status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG_FILE"; then
    exit 1
fi
exit 0

/* project.f */
source/fixedOrderPkg.sv
source/sampleStreamIf.sv
source/residualStreamIf.sv
source/blockSequencer.sv
source/fixedPredictor.sv
source/orderChooser.sv
source/fixedOrderSelect.sv
test/fixedOrderTb.sv

/* source/blockSequencer.sv */
`timescale 1ns/1ns

module blockSequencer
    import fixedOrderPkg::*;
(
    input  logic   iClock,
    input  logic   reset,
    input  sampleT sample,
    input  logic   sampleValid,
    sampleStreamIf.source samples
);

    // Position of the next sample within its block
    blockCountT count;
    logic       firstSample;
    logic       lastSample;

    assign firstSample = (count == '0);
    assign lastSample = (count == blockCountT'(BlockSize - 1));

    always_ff @(posedge iClock) begin
        if (reset) begin
            count <= '0;
        end else if (sampleValid) begin
            // Wrap straight into the next block
            if (lastSample) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // Zero latency tagging
    assign samples.sample = sample;
    assign samples.valid = sampleValid;
    assign samples.first = firstSample;
    assign samples.last = lastSample;

    // Count only moves on an accepted sample
    countHolds: assert property (
        @(posedge iClock) disable iff (reset)
        !sampleValid |=> $stable(count)
    ) else $error("blockSequencer count moved without a sample");

endmodule

/* source/fixedOrderPkg.sv */
package fixedOrderPkg;

    localparam int SampleWidth = 16;

    // Order-4 coefficient magnitudes sum to 16
    localparam int ResidualWidth = 21;

    localparam int ErrorWidth = 28;
    localparam int BlockSize = 64;
    localparam int OrderCount = 5;

    // Largest sum any order can reach over one block
    localparam int ErrorBound = BlockSize * 16 * (1 << (SampleWidth - 1));

    typedef logic signed [SampleWidth-1:0] sampleT;

    typedef logic signed [ResidualWidth-1:0] residualT;

    typedef logic [ErrorWidth-1:0] errorT;

    // Indexed by predictor order
    typedef residualT residualSetT [OrderCount];

    typedef logic [$clog2(BlockSize)-1:0] blockCountT;

    // Encoding equals the order number
    typedef enum logic [2:0] {
        orderZero  = 3'd0,
        orderOne   = 3'd1,
        orderTwo   = 3'd2,
        orderThree = 3'd3,
        orderFour  = 3'd4
    } predictorOrder;

endpackage

/* source/fixedOrderSelect.sv */
`timescale 1ns/1ns

module fixedOrderSelect
    import fixedOrderPkg::*;
(
    input  logic          iClock,
    input  logic          reset,
    input  sampleT        sample,
    input  logic          sampleValid,
    output predictorOrder bestOrder,
    output errorT         bestError,
    output logic          orderValid
);

    // Decode to execute
    sampleStreamIf samples ();

    // Execute to result
    residualStreamIf residuals ();

    blockSequencer i_blockSequencer (
        .iClock      (iClock),
        .reset       (reset),
        .sample      (sample),
        .sampleValid (sampleValid),
        .samples     (samples.source)
    );

    fixedPredictor i_fixedPredictor (
        .iClock    (iClock),
        .reset     (reset),
        .samples   (samples.sink),
        .residuals (residuals.source)
    );

    orderChooser i_orderChooser (
        .iClock     (iClock),
        .reset      (reset),
        .residuals  (residuals.sink),
        .bestOrder  (bestOrder),
        .bestError  (bestError),
        .orderValid (orderValid)
    );

endmodule

/* source/fixedPredictor.sv */
`timescale 1ns/1ns

module fixedPredictor
    import fixedOrderPkg::*;
(
    input  logic iClock,
    input  logic reset,
    sampleStreamIf.sink     samples,
    residualStreamIf.source residuals
);

    // history[0] is the previous sample
    sampleT      history [OrderCount-1];
    residualT    current;
    residualT    past [OrderCount-1];
    residualSetT residualNext;

    // Widen, and drop the history at block start
    always_comb begin
        current = residualT'(samples.sample);
        for (int i = 0; i < OrderCount - 1; i++) begin
            past[i] = samples.first ? '0 : residualT'(history[i]);
        end
    end

    // Binomial differences of orders 0 to 4
    always_comb begin
        residualNext[0] = current;
        residualNext[1] = residualT'(current - past[0]);
        residualNext[2] = residualT'(current - 2 * past[0] + past[1]);
        residualNext[3] = residualT'(current - 3 * past[0] + 3 * past[1] - past[2]);
        residualNext[4] = residualT'(current - 4 * past[0] + 6 * past[1]
                                     - 4 * past[2] + past[3]);
    end

    always_ff @(posedge iClock) begin
        if (samples.valid) begin
            history[0] <= samples.sample;
            // Reload with only this sample on a first
            for (int i = 1; i < OrderCount - 1; i++) begin
                history[i] <= samples.first ? '0 : history[i-1];
            end
        end
    end

    always_ff @(posedge iClock) begin
        if (samples.valid) begin
            residuals.residuals <= residualNext;
        end
    end

    always_ff @(posedge iClock) begin
        if (reset) begin
            residuals.valid <= 1'b0;
            residuals.first <= 1'b0;
            residuals.last <= 1'b0;
        end else begin
            residuals.valid <= samples.valid;
            residuals.first <= samples.valid & samples.first;
            residuals.last <= samples.valid & samples.last;
        end
    end

    validFollows: assert property (
        @(posedge iClock) disable iff (reset)
        1'b1 |=> residuals.valid == $past(samples.valid)
    ) else $error("fixedPredictor valid did not follow the sample strobe");

endmodule

/* source/orderChooser.sv */
`timescale 1ns/1ns

module orderChooser
    import fixedOrderPkg::*;
(
    input  logic          iClock,
    input  logic          reset,
    residualStreamIf.sink residuals,
    output predictorOrder bestOrder,
    output errorT         bestError,
    output logic          orderValid
);

    errorT                    accumulator [OrderCount];
    logic [ResidualWidth-1:0] magnitude [OrderCount];

    // Sums are complete, compare on the next edge
    logic                     compareReady;

    predictorOrder            winnerOrder;
    errorT                    winnerError;

    // Absolute value, the most negative residual still fits unsigned
    always_comb begin
        for (int i = 0; i < OrderCount; i++) begin
            if (residuals.residuals[i][ResidualWidth-1]) begin
                magnitude[i] = -residuals.residuals[i];
            end else begin
                magnitude[i] = residuals.residuals[i];
            end
        end
    end

    always_ff @(posedge iClock) begin
        if (residuals.valid) begin
            for (int i = 0; i < OrderCount; i++) begin
                // New block starts a fresh sum
                if (residuals.first) begin
                    accumulator[i] <= errorT'(magnitude[i]);
                end else begin
                    accumulator[i] <= accumulator[i] + errorT'(magnitude[i]);
                end
            end
        end
    end

    // Strict less than, so a tie keeps the lower order
    always_comb begin
        winnerOrder = orderZero;
        winnerError = accumulator[0];
        for (int i = 1; i < OrderCount; i++) begin
            if (accumulator[i] < winnerError) begin
                winnerOrder = predictorOrder'(i);
                winnerError = accumulator[i];
            end
        end
    end

    always_ff @(posedge iClock) begin
        if (reset) begin
            compareReady <= 1'b0;
            orderValid <= 1'b0;
            bestOrder <= orderZero;
            bestError <= '0;
        end else begin
            compareReady <= residuals.valid & residuals.last;
            orderValid <= compareReady;
            // Outputs hold until the next block result
            if (compareReady) begin
                bestOrder <= winnerOrder;
                bestError <= winnerError;
            end
        end
    end

    singlePulse: assert property (
        @(posedge iClock) disable iff (reset)
        orderValid |=> !orderValid
    ) else $error("orderChooser orderValid high for more than one cycle");

    // Result from one block cannot exceed the full-scale sum
    errorInRange: assert property (
        @(posedge iClock) disable iff (reset)
        orderValid |-> bestError <= ErrorBound
    ) else $error("orderChooser bestError above the block bound");

endmodule

/* source/residualStreamIf.sv */
`timescale 1ns/1ns

interface residualStreamIf
    import fixedOrderPkg::*;
();

    // One residual per predictor order
    residualSetT residuals;
    logic        valid;

    // Block position, only meaningful with valid
    logic        first;
    logic        last;

    modport source (
        output residuals,
        output valid,
        output first,
        output last
    );

    modport sink (
        input residuals,
        input valid,
        input first,
        input last
    );

endinterface

/* source/sampleStreamIf.sv */
`timescale 1ns/1ns

interface sampleStreamIf
    import fixedOrderPkg::*;
();

    sampleT sample;
    logic   valid;

    // Block position, only meaningful with valid
    logic   first;
    logic   last;

    modport source (
        output sample,
        output valid,
        output first,
        output last
    );

    modport sink (
        input sample,
        input valid,
        input first,
        input last
    );

endinterface

/* test/fixedOrderTb.sv */
`timescale 1ns/1ns

module fixedOrderTb
    import fixedOrderPkg::*;
();

    localparam int ClockPeriod = 4;
    localparam int ResetCycles = 16;
    localparam int LargestGap = 3;
    localparam int TotalBlocks = 12;
    localparam int MarginCycles = 1000;
    // Longest wait for a pending result
    localparam int CollectCycles = 16;

    logic          iClock;
    logic          reset;
    sampleT        sample;
    logic          sampleValid;
    predictorOrder bestOrder;
    errorT         bestError;
    logic          orderValid;

    sampleT        blockData [BlockSize];
    int            cycleCount = 0;
    int            errorCount = 0;
    int            checkCount = 0;
    int            testCount = 0;
    int            testErrors = 0;

    predictorOrder expOrder [$];
    errorT         expError [$];
    int            expCycle [$];
    predictorOrder obsOrder [$];
    errorT         obsError [$];
    int            obsCycle [$];

    fixedOrderSelect i_fixedOrderSelect (
        .iClock      (iClock),
        .reset       (reset),
        .sample      (sample),
        .sampleValid (sampleValid),
        .bestOrder   (bestOrder),
        .bestError   (bestError),
        .orderValid  (orderValid)
    );

    initial begin
        iClock = 1'b0;
        forever #(ClockPeriod / 2) iClock = ~iClock;
    end

    always @(posedge iClock) begin
        cycleCount <= cycleCount + 1;
    end

    // Every result pulse with the edge that raised it
    always @(negedge iClock) begin
        if (orderValid) begin
            obsOrder.push_back(bestOrder);
            obsError.push_back(bestError);
            obsCycle.push_back(cycleCount);
        end
    end

    initial begin
        #(ClockPeriod * (TotalBlocks * BlockSize * (LargestGap + 1) + MarginCycles));
        $display("Watchdog expired, the tests did not finish in time");
        $display("Testbench failed");
        $finish;
    end

    task automatic noteFailure();
        errorCount++;
        testErrors++;
    endtask

    task automatic compareOrder(input string name, input predictorOrder expected,
                                input predictorOrder actual);
        checkCount++;
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected %s got %s", $time, name,
                     expected.name(), actual.name());
            noteFailure();
        end
    endtask

    task automatic compareError(input string name, input errorT expected, input errorT actual);
        checkCount++;
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected %0d got %0d", $time, name, expected, actual);
            noteFailure();
        end
    endtask

    // Binomial residuals with zero history, lowest order wins a tie
    task automatic modelBlock(output predictorOrder order, output errorT error);
        longint sums [OrderCount];
        longint hist [OrderCount];
        longint res [OrderCount];
        int     best;
        for (int k = 0; k < OrderCount; k++) begin
            sums[k] = 0;
            hist[k] = 0;
        end
        for (int i = 0; i < BlockSize; i++) begin
            for (int k = OrderCount - 1; k > 0; k--) begin
                hist[k] = hist[k-1];
            end
            hist[0] = longint'(blockData[i]);
            res[0] = hist[0];
            res[1] = hist[0] - hist[1];
            res[2] = hist[0] - 2 * hist[1] + hist[2];
            res[3] = hist[0] - 3 * hist[1] + 3 * hist[2] - hist[3];
            res[4] = hist[0] - 4 * hist[1] + 6 * hist[2] - 4 * hist[3] + hist[4];
            for (int k = 0; k < OrderCount; k++) begin
                sums[k] += (res[k] < 0) ? -res[k] : res[k];
            end
        end
        best = 0;
        for (int k = 1; k < OrderCount; k++) begin
            if (sums[k] < sums[best]) begin
                best = k;
            end
        end
        order = predictorOrder'(best[2:0]);
        error = errorT'(sums[best]);
    endtask

    // Leaves sampleValid high so a following block runs back to back
    task automatic feedBlock(input int maxGap, output int lastEdge);
        int gap;
        lastEdge = 0;
        for (int i = 0; i < BlockSize; i++) begin
            sample = blockData[i];
            sampleValid = 1'b1;
            if (i == BlockSize - 1) begin
                lastEdge = cycleCount + 1;
            end
            @(negedge iClock);
            gap = (maxGap > 0) ? int'($urandom_range(maxGap, 0)) : 0;
            if (gap > 0 && i < BlockSize - 1) begin
                sampleValid = 1'b0;
                repeat (gap) @(negedge iClock);
            end
        end
    endtask

    task automatic runModelBlock(input int maxGap);
        predictorOrder order;
        errorT         error;
        int            lastEdge;
        modelBlock(order, error);
        feedBlock(maxGap, lastEdge);
        expOrder.push_back(order);
        expError.push_back(error);
        expCycle.push_back(lastEdge + 2);
    endtask

    task automatic runHandBlock(input predictorOrder order, input errorT error);
        int lastEdge;
        feedBlock(0, lastEdge);
        expOrder.push_back(order);
        expError.push_back(error);
        expCycle.push_back(lastEdge + 2);
    endtask

    task automatic checkResults(input string testName);
        int waited;
        int gotCycle;
        int wantCycle;
        sampleValid = 1'b0;
        waited = 0;
        while (obsOrder.size() < expOrder.size() && waited < CollectCycles) begin
            @(negedge iClock);
            waited++;
        end
        // Room for a late or extra pulse to show up
        repeat (CollectCycles) @(negedge iClock);
        checkCount++;
        if (obsOrder.size() < expOrder.size()) begin
            $display("%s: only %0d orderValid pulses for %0d blocks", testName,
                     obsOrder.size(), expOrder.size());
            noteFailure();
        end else if (obsOrder.size() > expOrder.size()) begin
            $display("%s: %0d orderValid pulses for only %0d blocks", testName,
                     obsOrder.size(), expOrder.size());
            noteFailure();
        end
        while (obsOrder.size() > 0 && expOrder.size() > 0) begin
            compareOrder("bestOrder", expOrder.pop_front(), obsOrder.pop_front());
            compareError("bestError", expError.pop_front(), obsError.pop_front());
            gotCycle = obsCycle.pop_front();
            wantCycle = expCycle.pop_front();
            checkCount++;
            if (gotCycle != wantCycle) begin
                $display("%s: orderValid came at cycle %0d instead of cycle %0d", testName,
                         gotCycle, wantCycle);
                noteFailure();
            end
        end
        obsOrder.delete();
        obsError.delete();
        obsCycle.delete();
        expOrder.delete();
        expError.delete();
        expCycle.delete();
        $display("%s finished with %0d errors", testName, testErrors);
        testCount++;
        testErrors = 0;
    endtask

    task automatic afterResetTest();
        repeat (8) @(negedge iClock);
        checkCount++;
        if (obsOrder.size() != 0) begin
            $display("orderValid pulsed during or right after reset");
            noteFailure();
            obsOrder.delete();
            obsError.delete();
            obsCycle.delete();
        end
        compareOrder("bestOrder", orderZero, bestOrder);
        compareError("bestError", '0, bestError);
        // All orders sum to zero, tie goes to order zero
        for (int i = 0; i < BlockSize; i++) begin
            blockData[i] = '0;
        end
        runHandBlock(orderZero, '0);
        checkResults("After reset");
    endtask

    task automatic shapeTest();
        for (int i = 0; i < BlockSize; i++) begin
            blockData[i] = sampleT'(-1234);
        end
        runHandBlock(orderOne, errorT'(1234));
        for (int i = 0; i < BlockSize; i++) begin
            blockData[i] = sampleT'(300 * i);
        end
        runHandBlock(orderTwo, errorT'(300));
        // Orders 3 and 4 tie at 8
        for (int i = 0; i < BlockSize; i++) begin
            blockData[i] = sampleT'(4 * i * i);
        end
        runHandBlock(orderThree, errorT'(8));
        checkResults("Constant, ramp and quadratic");
    endtask

    task automatic fullScaleTest();
        for (int i = 0; i < BlockSize; i++) begin
            blockData[i] = (i % 2 == 1) ? sampleT'(-32768) : sampleT'(32767);
        end
        runModelBlock(0);
        checkResults("Full scale alternating");
    endtask

    task automatic randomGapTest();
        for (int b = 0; b < 4; b++) begin
            for (int i = 0; i < BlockSize; i++) begin
                blockData[i] = sampleT'($urandom);
            end
            runModelBlock(LargestGap);
        end
        checkResults("Random with idle gaps");
    endtask

    // A constant block between random ones exposes any stale history
    task automatic backToBackTest();
        for (int b = 0; b < 3; b++) begin
            for (int i = 0; i < BlockSize; i++) begin
                blockData[i] = (b == 1) ? sampleT'(500) : sampleT'($urandom);
            end
            runModelBlock(0);
        end
        checkResults("Back to back blocks");
    endtask

    initial begin
        void'($urandom(37063));
        reset = 1'b1;
        sample = '0;
        sampleValid = 1'b0;
        repeat (ResetCycles) @(posedge iClock);
        @(negedge iClock);
        reset = 1'b0;
        afterResetTest();
        shapeTest();
        fullScaleTest();
        randomGapTest();
        backToBackTest();
        $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
